//--- common/cache_params.svh
// Cache directory parameters
`ifndef CACHE_PARAMS_SVH
`define CACHE_PARAMS_SVH

// Geometry, ways must be a power of two
`define CACHE_WAYS 4
`define CACHE_SETS 16

// Address split
`define ADDR_BITS 16
`define OFFSET_BITS 4

// Derived widths
`define WAY_BITS $clog2(`CACHE_WAYS)
`define SET_BITS $clog2(`CACHE_SETS)
`define TAG_BITS (`ADDR_BITS - `SET_BITS - `OFFSET_BITS)

`endif

//--- common/cachePkg.sv
// Cache directory types
`default_nettype none

`include "cache_params.svh"

package cachePkg;

  // Address field types
  typedef logic [`TAG_BITS-1:0]    tagT;
  typedef logic [`SET_BITS-1:0]    setT;
  typedef logic [`OFFSET_BITS-1:0] offsetT;

  // Field view of an address, tag in the top bits
  typedef struct packed {
    tagT    tag;
    setT    set;
    offsetT offset;
  } cacheAddrFieldsT;

  // Same address word, either raw or split into fields
  typedef union packed {
    logic [`ADDR_BITS-1:0] raw;
    cacheAddrFieldsT       fields;
  } cacheAddrT;

  // One bit per way
  typedef logic [`CACHE_WAYS-1:0] wayT;

  // Tree state, one bit per internal node, root at bit 0
  typedef logic [`CACHE_WAYS-2:0] lruT;

  // Lookup request, sampled with req
  typedef struct packed {
    cacheAddrT addr;
  } lookupReqT;

  // Lookup answer, held from one done to the next
  typedef struct packed {
    logic hit;
    wayT  way;
  } lookupRespT;

endpackage

`default_nettype wire

//--- cacheLRU/cacheLRU.sv
// Tree pseudo-LRU replacement
`timescale 1ns/10ps
`default_nettype none

`include "cache_params.svh"

module cacheLRU
  import cachePkg::*;
(
  input  logic clk,
  input  logic reset,
  // Set looked up in the request cycle
  input  setT  readSet,
  // Set of the lookup being completed
  input  setT  writeSet,
  input  logic lruWriteEn,
  // Miss, so the tree moves toward the victim instead of the hit way
  input  logic useVictim,
  input  wayT  hitWay,
  input  wayT  validWay,
  output wayT  victimWay
);

  localparam int WayBits = `WAY_BITS;

  lruT                lruMem [`CACHE_SETS];
  lruT                currLru;
  lruT                nextLru;
  logic [WayBits-1:0] hitIdx;
  logic [WayBits-1:0] freeIdx;
  logic [WayBits-1:0] treeIdx;
  logic [WayBits-1:0] victimIdx;
  logic [WayBits-1:0] useIdx;
  logic               allValid;

  ////////////////////////////////////////////////////////////////////////////
  // Victim selection
  ////////////////////////////////////////////////////////////////////////////

  assign allValid = &validWay;

  // Lowest invalid way
  always_comb begin
    freeIdx = '0;
    for (int w = `CACHE_WAYS - 1; w >= 0; w--) begin
      if (!validWay[w]) freeIdx = WayBits'(w);
    end
  end

  // Walk from the root, node bit 0 goes left, 1 goes right
  // Children of node n sit at 2n+1 and 2n+2
  always_comb begin
    int walkNode;
    walkNode = 0;
    for (int lvl = 0; lvl < WayBits; lvl++) begin
      treeIdx[WayBits-1-lvl] = currLru[walkNode];
      walkNode = 2 * walkNode + 1 + int'(currLru[walkNode]);
    end
  end

  assign victimIdx = allValid ? treeIdx : freeIdx;

  // Back to one-hot
  always_comb begin
    victimWay = '0;
    victimWay[victimIdx] = 1'b1;
  end

  ////////////////////////////////////////////////////////////////////////////
  // Tree update
  ////////////////////////////////////////////////////////////////////////////

  // Hit way is one-hot, OR of the set indices gives its number
  always_comb begin
    hitIdx = '0;
    for (int w = 0; w < `CACHE_WAYS; w++) begin
      if (hitWay[w]) hitIdx = hitIdx | WayBits'(w);
    end
  end

  assign useIdx = useVictim ? victimIdx : hitIdx;

  // Nodes on the path of the used way point to the other side
  // Nodes off the path keep their value
  always_comb begin
    int pathNode;
    nextLru = currLru;
    pathNode = 0;
    for (int lvl = 0; lvl < WayBits; lvl++) begin
      nextLru[pathNode] = ~useIdx[WayBits-1-lvl];
      pathNode = 2 * pathNode + 1 + int'(useIdx[WayBits-1-lvl]);
    end
  end

  ////////////////////////////////////////////////////////////////////////////
  // State memory
  ////////////////////////////////////////////////////////////////////////////

  // Two ports, read every cycle, write at the end of a lookup
  always_ff @(posedge clk) begin
    if (reset) begin
      for (int s = 0; s < `CACHE_SETS; s++) begin
        lruMem[s] <= '0;
      end
      currLru <= '0;
    end else begin
      if (lruWriteEn) lruMem[writeSet] <= nextLru;
      // Same set written and read, pass the new tree on
      if (lruWriteEn && (writeSet == readSet)) currLru <= nextLru;
      else currLru <= lruMem[readSet];
    end
  end

endmodule

`default_nettype wire

//--- hdl/cacheWays.sv
// Tag and valid ways
`timescale 1ns/10ps
`default_nettype none

`include "cache_params.svh"

module cacheWays
  import cachePkg::*;
(
  input  logic clk,
  input  logic reset,
  // Clear every valid bit of every set
  input  logic invalidateAll,
  input  logic fillEn,
  input  setT  readSet,
  input  setT  writeSet,
  input  tagT  writeTag,
  // Tag of the lookup in the compare cycle
  input  tagT  cmpTag,
  input  wayT  fillWay,
  output wayT  hitWay,
  output wayT  validWay
);

  tagT                    tagMem [`CACHE_WAYS][`CACHE_SETS];
  logic [`CACHE_SETS-1:0] validBits [`CACHE_WAYS];
  tagT                    tagRd [`CACHE_WAYS];

  ////////////////////////////////////////////////////////////////////////////
  // Tag storage
  ////////////////////////////////////////////////////////////////////////////

  // Synchronous read, tags of the set are valid one cycle later
  always_ff @(posedge clk) begin
    for (int w = 0; w < `CACHE_WAYS; w++) begin
      if (fillEn && fillWay[w]) tagMem[w][writeSet] <= writeTag;
      tagRd[w] <= tagMem[w][readSet];
    end
  end

  ////////////////////////////////////////////////////////////////////////////
  // Valid bits
  ////////////////////////////////////////////////////////////////////////////

  always_ff @(posedge clk) begin
    if (reset) begin
      for (int w = 0; w < `CACHE_WAYS; w++) begin
        validBits[w] <= '0;
      end
      validWay <= '0;
    end else begin
      for (int w = 0; w < `CACHE_WAYS; w++) begin
        // Invalidate overrides any fill
        if (invalidateAll) validBits[w] <= '0;
        else if (fillEn && fillWay[w]) validBits[w][writeSet] <= 1'b1;
        // Read alongside the tags
        validWay[w] <= validBits[w][readSet];
      end
    end
  end

  // Compare
  // Only valid ways can hit
  always_comb begin
    for (int w = 0; w < `CACHE_WAYS; w++) begin
      hitWay[w] = validWay[w] && (tagRd[w] == cmpTag);
    end
  end

endmodule

`default_nettype wire

//--- hdl/cacheCtrl.sv
// Lookup sequencing
`timescale 1ns/10ps
`default_nettype none

module cacheCtrl
  import cachePkg::*;
(
  input  logic       clk,
  input  logic       reset,
  input  logic       req,
  input  logic       invalidate,
  input  lookupReqT  reqData,
  input  wayT        hitWay,
  input  wayT        victimWay,
  output logic       ready,
  output logic       done,
  output lookupRespT resp,
  output setT        readSet,
  output setT        writeSet,
  output tagT        writeTag,
  output tagT        cmpTag,
  output logic       fillEn,
  output logic       lruWriteEn,
  output logic       useVictim,
  output logic       invalidateAll,
  output wayT        fillWay
);

  typedef enum logic {Idle, Compare} stateT;

  stateT     state;
  lookupReqT reqQ;
  logic      accept;
  logic      miss;

  // Invalidate wins over a request in the same cycle
  assign accept = req & ready & ~invalidate;
  assign miss   = ~|hitWay;

  // Request word, held for the compare cycle
  always_ff @(posedge clk) begin
    if (accept) reqQ <= reqData;
  end

  // Arrays read the incoming set straight away
  assign readSet  = reqData.addr.fields.set;
  assign writeSet = reqQ.addr.fields.set;
  assign writeTag = reqQ.addr.fields.tag;
  assign cmpTag   = reqQ.addr.fields.tag;

  // Compare cycle writes, these land on the closing edge
  assign fillEn     = (state == Compare) & miss;
  assign lruWriteEn = (state == Compare);
  assign useVictim  = miss;
  assign fillWay    = victimWay;

  ////////////////////////////////////////////////////////////////////////////
  // FSM
  ////////////////////////////////////////////////////////////////////////////

  always_ff @(posedge clk) begin
    if (reset) begin
      state         <= Idle;
      ready         <= 1'b1;
      done          <= 1'b0;
      resp          <= '0;
      invalidateAll <= 1'b0;
    end else begin
      done          <= 1'b0;
      invalidateAll <= 1'b0;
      case (state)
        Idle: begin
          // Clear cycle, busy while valid bits are wiped
          if (invalidate && ready) begin
            invalidateAll <= 1'b1;
            ready         <= 1'b0;
          end else if (accept) begin
            state <= Compare;
            ready <= 1'b0;
          end else ready <= 1'b1;
        end
        Compare: begin
          state     <= Idle;
          ready     <= 1'b1;
          done      <= 1'b1;
          resp.hit  <= ~miss;
          resp.way  <= miss ? victimWay : hitWay;
        end
        default: state <= Idle;
      endcase
    end
  end

endmodule

`default_nettype wire

//--- hdl/cacheTags.sv
// Cache tag directory
`timescale 1ns/10ps
`default_nettype none

module cacheTags
  import cachePkg::*;
(
  input  logic       clk,
  input  logic       reset,
  input  logic       req,
  input  lookupReqT  reqData,
  input  logic       invalidate,
  output logic       ready,
  output logic       done,
  output lookupRespT resp
);

  // Controller to arrays
  setT  readSet;
  setT  writeSet;
  tagT  writeTag;
  tagT  cmpTag;
  logic fillEn;
  logic lruWriteEn;
  logic useVictim;
  logic invalidateAll;
  wayT  fillWay;

  // Arrays to controller
  wayT  hitWay;
  wayT  validWay;
  wayT  victimWay;

  cacheCtrl ctrl_i (
    .clk, .reset, .req, .invalidate, .reqData, .hitWay, .victimWay,
    .ready, .done, .resp, .readSet, .writeSet, .writeTag, .cmpTag,
    .fillEn, .lruWriteEn, .useVictim, .invalidateAll, .fillWay
  );

  cacheWays ways_i (
    .clk, .reset, .invalidateAll, .fillEn, .readSet, .writeSet,
    .writeTag, .cmpTag, .fillWay, .hitWay, .validWay
  );

  // Replacement state
  cacheLRU lru_i (
    .clk, .reset, .readSet, .writeSet, .lruWriteEn, .useVictim,
    .hitWay, .validWay, .victimWay
  );

endmodule

`default_nettype wire

//--- sim/cacheTags_chk.sv
// Directory protocol assertions
`timescale 1ns/10ps
`default_nettype none

module cacheTags_chk
  import cachePkg::*;
(
  input logic       clk,
  input logic       reset,
  input logic       req,
  input logic       invalidate,
  input logic       ready,
  input logic       done,
  input lookupRespT resp
);

  int   oneHotFails = 0;
  int   latencyFails = 0;
  int   readyFails = 0;
  logic accepted;

  // Only a req without a coinciding invalidate is taken
  assign accepted = req && ready && !invalidate;

  oneHotWay: assert property (@(posedge clk) disable iff (reset)
    done |-> $onehot(resp.way))
  else begin
    oneHotFails++;
    $error("resp.way not one-hot with done");
  end

  // Fixed latency of two cycles
  doneLatency: assert property (@(posedge clk) disable iff (reset)
    accepted |-> ##2 done)
  else begin
    latencyFails++;
    $error("done not two cycles after request");
  end

  readyDrop: assert property (@(posedge clk) disable iff (reset)
    accepted |=> !ready)
  else begin
    readyFails++;
    $error("ready still high after request");
  end

endmodule

bind cacheTags cacheTags_chk chk_i (
  .clk, .reset, .req, .invalidate, .ready, .done, .resp
);

`default_nettype wire

//--- sim/cacheTags_tb.sv
// Cache tag directory testbench
`timescale 1ns/10ps
`default_nettype none

`include "cache_params.svh"

module cacheTags_tb
  import cachePkg::*;
;

  localparam int ClkPeriod = 40;
  localparam int WayBits = `WAY_BITS;
  // Room for about 240 lookups with reset and margin
  localparam int LookupCount = 240;
  localparam int WatchdogCycles = 8 + LookupCount * 3 + 100;

  logic       clk = 1'b0;
  logic       reset;
  logic       req;
  lookupReqT  reqData;
  logic       invalidate;
  logic       ready;
  logic       done;
  lookupRespT resp;

  // Reference directory with tags, valid bits and trees per set
  tagT         mTag [`CACHE_SETS][`CACHE_WAYS];
  logic        mValid [`CACHE_SETS][`CACHE_WAYS];
  lruT         mTree [`CACHE_SETS];
  int          errors = 0;
  int          testCount = 0;
  int          assertFails = 0;
  logic [15:0] lfsrState = 16'd47;

  cacheTags cacheTags_i (
    .clk, .reset, .req, .reqData, .invalidate, .ready, .done, .resp
  );

  always #(ClkPeriod / 2) clk = ~clk;

  ////////////////////////////////////////////////////////////////////////////
  // Reference model
  ////////////////////////////////////////////////////////////////////////////

  // First invalid way or else the leaf the tree bits lead to
  function automatic int modelVictim(int set);
    int node;
    int idx;
    for (int w = 0; w < `CACHE_WAYS; w++) begin
      if (!mValid[set][w]) return w;
    end
    node = 0;
    idx = 0;
    for (int lvl = 0; lvl < WayBits; lvl++) begin
      idx = 2 * idx + int'(mTree[set][node]);
      node = 2 * node + 1 + int'(mTree[set][node]);
    end
    return idx;
  endfunction

  // Path nodes point away from the used way
  function automatic void touchTree(int set, int way);
    int node;
    int b;
    node = 0;
    for (int lvl = 0; lvl < WayBits; lvl++) begin
      b = (way >> (WayBits - 1 - lvl)) & 1;
      mTree[set][node] = (b == 0);
      node = 2 * node + 1 + b;
    end
  endfunction

  function automatic logic [`ADDR_BITS-1:0] makeAddr(int tag, int set, int offset);
    cacheAddrT a;
    a.fields.tag = tagT'(tag);
    a.fields.set = setT'(set);
    a.fields.offset = offsetT'(offset);
    return a.raw;
  endfunction

  // Fibonacci LFSR with taps 16 14 13 11
  function automatic logic [15:0] lfsrNext(logic [15:0] s);
    return {s[14:0], s[15] ^ s[13] ^ s[12] ^ s[10]};
  endfunction

  // One step per bit taken
  function automatic int randomBits(int n);
    int value;
    value = 0;
    for (int i = 0; i < n; i++) begin
      lfsrState = lfsrNext(lfsrState);
      value = (value << 1) | int'(lfsrState[0]);
    end
    return value;
  endfunction

  ////////////////////////////////////////////////////////////////////////////
  // Driver tasks
  ////////////////////////////////////////////////////////////////////////////

  task automatic reportError(string msg);
    $display("ERROR at %0t ns: %s", $time, msg);
    errors++;
  endtask

  task automatic finishTest(string name, int errBefore);
    testCount++;
    if (errors == errBefore) $display("Test %0d %s: ok", testCount, name);
    else $display("Test %0d %s: %0d errors", testCount, name, errors - errBefore);
  endtask

  // One lookup against the model from a falling edge
  task automatic lookupCheck(input logic [`ADDR_BITS-1:0] rawAddr,
                             output logic gotHit, output wayT gotWay);
    cacheAddrT a;
    int        set;
    int        expWay;
    logic      expHit;
    int        cycles;
    a.raw = rawAddr;
    set = int'(a.fields.set);
    expHit = 1'b0;
    expWay = 0;
    for (int w = 0; w < `CACHE_WAYS; w++) begin
      if (mValid[set][w] && mTag[set][w] == a.fields.tag) begin
        expHit = 1'b1;
        expWay = w;
      end
    end
    // Miss fills the victim
    if (!expHit) begin
      expWay = modelVictim(set);
      mTag[set][expWay] = a.fields.tag;
      mValid[set][expWay] = 1'b1;
    end
    touchTree(set, expWay);
    if (!ready) reportError("ready low when a request was due");
    reqData.addr = a;
    req = 1'b1;
    @(negedge clk);
    req = 1'b0;
    cycles = 1;
    while (!done && cycles < 8) begin
      @(negedge clk);
      cycles++;
    end
    if (!done) begin
      $display("Lookup of address %h got no done within 8 cycles", rawAddr);
      errors++;
    end else if (cycles != 2) begin
      reportError($sformatf("done after %0d cycles, expected 2", cycles));
    end
    if (resp.hit !== expHit || resp.way !== wayT'(1 << expWay)) begin
      reportError($sformatf("addr %h got hit %b way %b, expected hit %b way %b",
                            rawAddr, resp.hit, resp.way, expHit, wayT'(1 << expWay)));
    end
    gotHit = resp.hit;
    gotWay = resp.way;
  endtask

  // Invalidate strobe and wait for ready again
  task automatic clearDirectory();
    int cycles;
    invalidate = 1'b1;
    @(negedge clk);
    invalidate = 1'b0;
    if (ready) reportError("ready high in the clear cycle");
    cycles = 0;
    while (!ready && cycles < 8) begin
      @(negedge clk);
      cycles++;
    end
    if (!ready) begin
      $display("ready did not return after invalidate");
      errors++;
    end
    for (int s = 0; s < `CACHE_SETS; s++) begin
      for (int w = 0; w < `CACHE_WAYS; w++) mValid[s][w] = 1'b0;
    end
  endtask

  ////////////////////////////////////////////////////////////////////////////
  // Tests
  ////////////////////////////////////////////////////////////////////////////

  // Cold set fills ways in order
  task automatic coldFillTest();
    int   errBefore;
    logic hit;
    wayT  way;
    errBefore = errors;
    for (int i = 0; i < `CACHE_WAYS; i++) begin
      lookupCheck(makeAddr(8'h40 + i, 0, i), hit, way);
      if (hit || way !== wayT'(1 << i)) reportError($sformatf("cold fill %0d misplaced", i));
    end
    finishTest("cold fill", errBefore);
  endtask

  task automatic repeatHitTest();
    int   errBefore;
    logic hit;
    wayT  way;
    errBefore = errors;
    for (int i = 0; i < `CACHE_WAYS; i++) begin
      lookupCheck(makeAddr(8'h40 + i, 0, 15 - i), hit, way);
      if (!hit || way !== wayT'(1 << i)) reportError($sformatf("tag %0d did not hit", i));
    end
    finishTest("repeat hits", errBefore);
  endtask

  // Hits shape the tree and a new tag evicts the predicted way
  task automatic evictionTest();
    int   errBefore;
    int   victim;
    tagT  evictTag;
    logic hit;
    wayT  way;
    errBefore = errors;
    lookupCheck(makeAddr(8'h42, 0, 0), hit, way);
    lookupCheck(makeAddr(8'h40, 0, 0), hit, way);
    lookupCheck(makeAddr(8'h43, 0, 0), hit, way);
    victim = modelVictim(0);
    evictTag = mTag[0][victim];
    lookupCheck(makeAddr(8'h55, 0, 0), hit, way);
    if (hit || way !== wayT'(1 << victim)) reportError("new tag did not evict predicted way");
    lookupCheck(makeAddr(int'(evictTag), 0, 0), hit, way);
    if (hit) reportError("evicted tag still hits");
    finishTest("eviction", errBefore);
  endtask

  task automatic invalidateTest();
    int   errBefore;
    logic hit;
    wayT  way;
    errBefore = errors;
    clearDirectory();
    for (int i = 0; i < `CACHE_WAYS; i++) begin
      lookupCheck(makeAddr(8'h40 + i, 0, 0), hit, way);
      if (hit || way !== wayT'(1 << i)) reportError($sformatf("refill %0d misplaced", i));
    end
    finishTest("invalidate", errBefore);
  endtask

  // Same tags in two sets where traffic in one leaves the other alone
  task automatic setIsolationTest();
    int   errBefore;
    logic hit;
    wayT  way;
    errBefore = errors;
    for (int i = 0; i < `CACHE_WAYS; i++) lookupCheck(makeAddr(8'h10 + i, 1, 0), hit, way);
    for (int i = 0; i < `CACHE_WAYS; i++) lookupCheck(makeAddr(8'h10 + i, 2, 0), hit, way);
    for (int i = `CACHE_WAYS - 1; i >= 0; i--) lookupCheck(makeAddr(8'h10 + i, 1, 0), hit, way);
    lookupCheck(makeAddr(8'h77, 2, 0), hit, way);
    lookupCheck(makeAddr(8'h78, 2, 0), hit, way);
    for (int i = 0; i < `CACHE_WAYS; i++) begin
      lookupCheck(makeAddr(8'h10 + i, 1, 0), hit, way);
      if (!hit) reportError($sformatf("set 1 lost tag %0d", i));
    end
    finishTest("set isolation", errBefore);
  endtask

  // Eight tags over four sets mix misses and evictions with hits
  task automatic randomStreamTest();
    int   errBefore;
    int   tag;
    int   set;
    int   offset;
    logic hit;
    wayT  way;
    errBefore = errors;
    for (int n = 0; n < 200; n++) begin
      tag = 8'h20 + randomBits(3);
      set = 4 + randomBits(2);
      offset = randomBits(4);
      lookupCheck(makeAddr(tag, set, offset), hit, way);
    end
    finishTest("random stream", errBefore);
  endtask

  ////////////////////////////////////////////////////////////////////////////
  // Sequence
  ////////////////////////////////////////////////////////////////////////////

  initial begin
    #(WatchdogCycles * ClkPeriod);
    $display("Watchdog expired, the tests did not finish in time");
    $display("=== FAIL ===");
    $finish;
  end

  initial begin
    reset = 1'b1;
    req = 1'b0;
    invalidate = 1'b0;
    reqData = '0;
    for (int s = 0; s < `CACHE_SETS; s++) begin
      mTree[s] = '0;
      for (int w = 0; w < `CACHE_WAYS; w++) mValid[s][w] = 1'b0;
    end
    repeat (8) @(negedge clk);
    reset = 1'b0;
    @(negedge clk);
    coldFillTest();
    repeatHitTest();
    evictionTest();
    invalidateTest();
    setIsolationTest();
    randomStreamTest();
    // Protocol assertions bound into the DUT
    assertFails = cacheTags_i.chk_i.oneHotFails + cacheTags_i.chk_i.latencyFails
                  + cacheTags_i.chk_i.readyFails;
    $display("Tests run: %0d, errors: %0d, assertion failures: %0d",
             testCount, errors, assertFails);
    if (errors == 0 && assertFails == 0) begin
      $display("=== PASS ===");
    end else begin
      $display("=== FAIL ===");
    end
    $finish;
  end

endmodule

`default_nettype wire

//--- cacheTags.f
+incdir+common
common/cachePkg.sv
cacheLRU/cacheLRU.sv
hdl/cacheWays.sv
hdl/cacheCtrl.sv
hdl/cacheTags.sv
sim/cacheTags_chk.sv
sim/cacheTags_tb.sv

//--- Bender.yml
package:
  name: cacheTags

sources:
  - include_dirs:
      - common
    files:
      - common/cachePkg.sv
      - cacheLRU/cacheLRU.sv
      - hdl/cacheWays.sv
      - hdl/cacheCtrl.sv
      - hdl/cacheTags.sv
      - target: simulation
        files:
          - sim/cacheTags_chk.sv
          - sim/cacheTags_tb.sv

export_include_dirs:
  - common
